//--- Makefile
VERILATOR ?= verilator
TOP       ?= bp_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= \*\* PASS \*\*

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(shell cat $(FILELIST) | grep -v '^+') verif/bp_tb_ref.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+verif
logic/bp_pkg.sv
logic/bp_tables.sv
logic/bp_predict.sv
logic/bp_rollback.sv
logic/bp_csr.sv
logic/bp_top.sv
verif/bp_tb.sv

//--- logic/bp_csr.sv
`default_nettype none

module bp_csr (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    cyc,
  input  wire                    stb,
  input  wire                    we,
  input  wire bp_pkg::wb_addr_t  adr,
  input  wire bp_pkg::wb_data_t  dat_w,
  input  wire                    mispredict_evt,
  input  wire                    ld_violate_evt,
  output bp_pkg::wb_data_t       dat_r,
  output logic                   ack,
  output logic                   predict_enable
);

  logic             req;
  bp_pkg::wb_addr_t reg_sel;
  logic             wr_ctrl;
  logic             wr_mispredict;
  logic             wr_ld_violate;
  bp_pkg::wb_data_t mispredict_cnt;
  bp_pkg::wb_data_t ld_violate_cnt;

  // clear beats a same-cycle event, saturate at all ones
  function automatic bp_pkg::wb_data_t cnt_next(input bp_pkg::wb_data_t cnt, input logic evt,
                                                input logic clr);
    bp_pkg::wb_data_t n;
    n = cnt;
    if (clr) begin
      n = '0;
    end else if (evt && cnt != '1) begin
      n = cnt + 32'd1;
    end
    return n;
  endfunction

  assign req     = cyc && stb && !ack;  // one ack per strobe
  assign reg_sel = {adr[3:2], 2'b00};

  assign wr_ctrl       = req && we && reg_sel == bp_pkg::reg_ctrl;
  assign wr_mispredict = req && we && reg_sel == bp_pkg::reg_mispredict;
  assign wr_ld_violate = req && we && reg_sel == bp_pkg::reg_ld_violate;

  always_ff @(posedge clock) begin
    if (reset) begin
      ack            <= 1'b0;
      predict_enable <= 1'b1;
      mispredict_cnt <= '0;
      ld_violate_cnt <= '0;
    end else begin
      ack <= req;
      if (wr_ctrl) begin
        predict_enable <= dat_w[0];
      end
      mispredict_cnt <= cnt_next(mispredict_cnt, mispredict_evt, wr_mispredict);
      ld_violate_cnt <= cnt_next(ld_violate_cnt, ld_violate_evt, wr_ld_violate);
    end
  end

  always_ff @(posedge clock) begin
    if (req) begin
      case (reg_sel)
        bp_pkg::reg_ctrl:       dat_r <= bp_pkg::wb_data_t'(predict_enable);
        bp_pkg::reg_mispredict: dat_r <= mispredict_cnt;
        bp_pkg::reg_ld_violate: dat_r <= ld_violate_cnt;
        default:                dat_r <= '0;
      endcase
    end
  end

  ack_one_cycle: assert property (@(posedge clock) disable iff (reset) ack |=> !ack);

endmodule

`default_nettype wire

//--- logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int num_super   = 2;
  localparam int bh_idx_bits = 4;
  localparam int bh_entries  = 2 ** bh_idx_bits;

  typedef logic [31:0]            pc_t;
  typedef logic [31:0]            inst_t;     // opcode in [31:26]
  typedef logic [bh_idx_bits-1:0] bh_idx_t;   // pc[5:2]
  typedef logic [1:0]             counter_t;  // 2 and 3 predict taken
  typedef logic [4:0]             rob_idx_t;
  typedef logic [4:0]             fl_idx_t;
  typedef logic [2:0]             lsq_idx_t;
  typedef logic [3:0]             wb_addr_t;
  typedef logic [31:0]            wb_data_t;

  // conditional branches
  localparam logic [5:0] op_blbc = 6'h38;
  localparam logic [5:0] op_beq  = 6'h39;
  localparam logic [5:0] op_blt  = 6'h3a;
  localparam logic [5:0] op_ble  = 6'h3b;
  localparam logic [5:0] op_blbs = 6'h3c;
  localparam logic [5:0] op_bne  = 6'h3d;
  localparam logic [5:0] op_bge  = 6'h3e;
  localparam logic [5:0] op_bgt  = 6'h3f;

  localparam logic [5:0] op_br      = 6'h30;
  localparam logic [5:0] op_bsr     = 6'h34;
  localparam logic [5:0] op_jsr_grp = 6'h1a;  // jmp, jsr, ret, jsr_co

  localparam counter_t counter_reset = 2'b01;  // weakly not taken

  localparam wb_addr_t reg_ctrl       = 4'h0;
  localparam wb_addr_t reg_mispredict = 4'h4;
  localparam wb_addr_t reg_ld_violate = 4'h8;

endpackage

`default_nettype wire

//--- logic/bp_predict.sv
`default_nettype none

module bp_predict (
  input  wire bp_pkg::pc_t                   fetch_pc [bp_pkg::num_super],
  input  wire bp_pkg::inst_t                 fetch_inst [bp_pkg::num_super],
  input  wire [bp_pkg::num_super-1:0]        fetch_valid,
  input  wire                                predict_enable,
  input  wire                                rollback_en,
  input  wire bp_pkg::pc_t                   rollback_target,
  input  wire bp_pkg::counter_t              lookup_ctr [bp_pkg::num_super],
  input  wire bp_pkg::pc_t                   lookup_target [bp_pkg::num_super],
  output bp_pkg::bh_idx_t                    lookup_idx [bp_pkg::num_super],
  output logic [bp_pkg::num_super-1:0]       pred_take,
  output logic [bp_pkg::num_super-1:0]       pred_valid,
  output bp_pkg::pc_t                        pred_target
);

  logic [bp_pkg::num_super-1:0] is_cond;
  logic [bp_pkg::num_super-1:0] is_uncond;
  logic [bp_pkg::num_super-1:0] take;

  always_comb begin
    for (int i = 0; i < bp_pkg::num_super; i++) begin
      is_cond[i]    = 1'b0;
      is_uncond[i]  = 1'b0;
      lookup_idx[i] = fetch_pc[i][bp_pkg::bh_idx_bits+1:2];
      if (fetch_valid[i]) begin
        case (fetch_inst[i][31:26])
          bp_pkg::op_blbc, bp_pkg::op_beq, bp_pkg::op_blt, bp_pkg::op_ble,
          bp_pkg::op_blbs, bp_pkg::op_bne, bp_pkg::op_bge, bp_pkg::op_bgt: begin
            is_cond[i] = 1'b1;
          end
          bp_pkg::op_br, bp_pkg::op_bsr, bp_pkg::op_jsr_grp: begin
            is_uncond[i] = 1'b1;
          end
          default: begin
          end
        endcase
      end
      // counter only consulted when enabled
      take[i] = is_uncond[i] || (is_cond[i] && predict_enable && lookup_ctr[i][1]);
    end
  end

  assign pred_take = take | {bp_pkg::num_super{rollback_en}};

  assign pred_valid[0] = fetch_valid[0] && !rollback_en;
  assign pred_valid[1] = fetch_valid[1] && !rollback_en && !take[0];  // lane 1 squashed

  assign pred_target = rollback_en ? rollback_target :
                       take[0]     ? lookup_target[0] :
                       take[1]     ? lookup_target[1] :
                                     fetch_pc[1] + 32'd4;

endmodule

`default_nettype wire

//--- logic/bp_rollback.sv
`default_nettype none

module bp_rollback (
  input  wire                                clock,
  input  wire                                reset,
  input  wire [bp_pkg::num_super-1:0]        br_done,
  input  wire [bp_pkg::num_super-1:0]        br_taken,
  input  wire bp_pkg::pc_t                   br_npc [bp_pkg::num_super],
  input  wire bp_pkg::pc_t                   br_target_pc [bp_pkg::num_super],
  input  wire bp_pkg::pc_t                   br_pred_target [bp_pkg::num_super],
  input  wire bp_pkg::rob_idx_t              br_rob_idx [bp_pkg::num_super],
  input  wire bp_pkg::fl_idx_t               br_fl_idx [bp_pkg::num_super],
  input  wire bp_pkg::lsq_idx_t              br_sq_idx [bp_pkg::num_super],
  input  wire bp_pkg::lsq_idx_t              br_lq_idx [bp_pkg::num_super],
  input  wire                                ld_violate,
  input  wire bp_pkg::rob_idx_t              ld_rob_idx,
  input  wire bp_pkg::fl_idx_t               ld_fl_idx,
  input  wire bp_pkg::lsq_idx_t              ld_sq_idx,
  input  wire bp_pkg::lsq_idx_t              ld_lq_idx,
  input  wire bp_pkg::pc_t                   ld_target_pc,
  input  wire bp_pkg::rob_idx_t              dispatch_rob_idx,
  output logic                               rollback_en,
  output bp_pkg::rob_idx_t                   rollback_rob_idx,
  output bp_pkg::fl_idx_t                    rollback_fl_idx,
  output bp_pkg::lsq_idx_t                   rollback_sq_idx,
  output bp_pkg::lsq_idx_t                   rollback_lq_idx,
  output bp_pkg::pc_t                        rollback_target,
  output logic [bp_pkg::num_super-1:0]       ctr_upd,
  output bp_pkg::bh_idx_t                    ctr_upd_idx [bp_pkg::num_super],
  output logic [bp_pkg::num_super-1:0]       ctr_taken,
  output logic                               btb_wr,
  output bp_pkg::bh_idx_t                    btb_wr_idx,
  output bp_pkg::pc_t                        btb_wr_target,
  output logic                               mispredict_evt,
  output logic                               ld_violate_evt
);

  bp_pkg::pc_t                  actual_npc [bp_pkg::num_super];
  bp_pkg::pc_t                  br_pc      [bp_pkg::num_super];
  bp_pkg::rob_idx_t             br_age     [bp_pkg::num_super];
  bp_pkg::rob_idx_t             ld_age;
  logic [bp_pkg::num_super-1:0] wrong;
  logic                         br_req;
  logic                         br_sel;
  logic                         br_wins;

  always_comb begin
    for (int i = 0; i < bp_pkg::num_super; i++) begin
      actual_npc[i] = br_taken[i] ? br_target_pc[i] : br_npc[i];
      wrong[i]      = br_done[i] && (actual_npc[i] != br_pred_target[i]);
      br_age[i]     = dispatch_rob_idx - br_rob_idx[i];  // wraps mod 32
      br_pc[i]      = br_npc[i] - 32'd4;  // branch's own pc indexes the tables
      ctr_upd_idx[i] = br_pc[i][bp_pkg::bh_idx_bits+1:2];
    end
  end

  assign ld_age = dispatch_rob_idx - ld_rob_idx;
  assign br_req = |wrong;

  // lane 1 only if strictly older, ties to lane 0
  assign br_sel  = !wrong[0] || (wrong[1] && br_age[1] > br_age[0]);
  assign br_wins = br_req && (!ld_violate || br_age[br_sel] >= ld_age);

  assign rollback_en      = br_req || ld_violate;
  assign rollback_rob_idx = br_wins ? br_rob_idx[br_sel] : ld_rob_idx;
  assign rollback_fl_idx  = br_wins ? br_fl_idx[br_sel]  : ld_fl_idx;
  assign rollback_sq_idx  = br_wins ? br_sq_idx[br_sel]  : ld_sq_idx;
  assign rollback_lq_idx  = br_wins ? br_lq_idx[br_sel]  : ld_lq_idx;
  assign rollback_target  = br_wins ? actual_npc[br_sel] : ld_target_pc;

  // every resolved branch trains its counter
  assign ctr_upd   = br_done;
  assign ctr_taken = br_taken;

  assign btb_wr        = br_wins && br_taken[br_sel];
  assign btb_wr_idx    = ctr_upd_idx[br_sel];
  assign btb_wr_target = br_target_pc[br_sel];

  assign mispredict_evt = br_wins;
  assign ld_violate_evt = ld_violate && !br_wins;

  rollback_has_cause: assert property (@(posedge clock) disable iff (reset)
    rollback_en |-> ((|br_done) || ld_violate));

endmodule

`default_nettype wire

//--- logic/bp_tables.sv
`default_nettype none

module bp_tables (
  input  wire                                clock,
  input  wire                                reset,
  input  wire bp_pkg::bh_idx_t               lookup_idx [bp_pkg::num_super],
  input  wire [bp_pkg::num_super-1:0]        ctr_upd,
  input  wire bp_pkg::bh_idx_t               ctr_upd_idx [bp_pkg::num_super],
  input  wire [bp_pkg::num_super-1:0]        ctr_taken,
  input  wire                                btb_wr,
  input  wire bp_pkg::bh_idx_t               btb_wr_idx,
  input  wire bp_pkg::pc_t                   btb_wr_target,
  output bp_pkg::counter_t                   lookup_ctr [bp_pkg::num_super],
  output bp_pkg::pc_t                        lookup_target [bp_pkg::num_super]
);

  bp_pkg::counter_t ctr      [bp_pkg::bh_entries];
  bp_pkg::counter_t ctr_next [bp_pkg::bh_entries];
  bp_pkg::pc_t      btb      [bp_pkg::bh_entries];
  bp_pkg::pc_t      btb_next [bp_pkg::bh_entries];

  // one saturating step of a 2-bit counter
  function automatic bp_pkg::counter_t ctr_step(input bp_pkg::counter_t c, input logic taken);
    bp_pkg::counter_t n;
    n = c;
    if (taken && c != 2'b11) begin
      n = c + 2'd1;
    end else if (!taken && c != 2'b00) begin
      n = c - 2'd1;
    end
    return n;
  endfunction

  always_comb begin
    ctr_next = ctr;
    // lane 1 applies on top of lane 0, same entry moves twice
    for (int i = 0; i < bp_pkg::num_super; i++) begin
      if (ctr_upd[i]) begin
        ctr_next[ctr_upd_idx[i]] = ctr_step(ctr_next[ctr_upd_idx[i]], ctr_taken[i]);
      end
    end
  end

  always_comb begin
    btb_next = btb;
    if (btb_wr) begin
      btb_next[btb_wr_idx] = btb_wr_target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int e = 0; e < bp_pkg::bh_entries; e++) begin
        ctr[e] <= bp_pkg::counter_reset;
        btb[e] <= '0;
      end
    end else begin
      ctr <= ctr_next;
      btb <= btb_next;
    end
  end

  // lookups see this cycle's update
  always_comb begin
    for (int i = 0; i < bp_pkg::num_super; i++) begin
      lookup_ctr[i]    = ctr_next[lookup_idx[i]];
      lookup_target[i] = btb_next[lookup_idx[i]];
    end
  end

  for (genvar i = 0; i < bp_pkg::num_super; i++) begin : g_upd_chk
    ctr_idx_known: assert property (@(posedge clock) disable iff (reset)
      ctr_upd[i] |-> !$isunknown(ctr_upd_idx[i]));
  end

  btb_idx_known: assert property (@(posedge clock) disable iff (reset)
    btb_wr |-> !$isunknown(btb_wr_idx));

endmodule

`default_nettype wire

//--- logic/bp_top.sv
`default_nettype none

module bp_top (
  input  wire                                clock,
  input  wire                                reset,
  input  wire bp_pkg::pc_t                   fetch_pc [bp_pkg::num_super],
  input  wire bp_pkg::inst_t                 fetch_inst [bp_pkg::num_super],
  input  wire [bp_pkg::num_super-1:0]        fetch_valid,
  output logic [bp_pkg::num_super-1:0]       pred_take,
  output logic [bp_pkg::num_super-1:0]       pred_valid,
  output bp_pkg::pc_t                        pred_target,
  input  wire [bp_pkg::num_super-1:0]        br_done,
  input  wire [bp_pkg::num_super-1:0]        br_taken,
  input  wire bp_pkg::pc_t                   br_npc [bp_pkg::num_super],
  input  wire bp_pkg::pc_t                   br_target_pc [bp_pkg::num_super],
  input  wire bp_pkg::pc_t                   br_pred_target [bp_pkg::num_super],
  input  wire bp_pkg::rob_idx_t              br_rob_idx [bp_pkg::num_super],
  input  wire bp_pkg::fl_idx_t               br_fl_idx [bp_pkg::num_super],
  input  wire bp_pkg::lsq_idx_t              br_sq_idx [bp_pkg::num_super],
  input  wire bp_pkg::lsq_idx_t              br_lq_idx [bp_pkg::num_super],
  input  wire                                ld_violate,
  input  wire bp_pkg::rob_idx_t              ld_rob_idx,
  input  wire bp_pkg::fl_idx_t               ld_fl_idx,
  input  wire bp_pkg::lsq_idx_t              ld_sq_idx,
  input  wire bp_pkg::lsq_idx_t              ld_lq_idx,
  input  wire bp_pkg::pc_t                   ld_target_pc,
  input  wire bp_pkg::rob_idx_t              dispatch_rob_idx,
  output logic                               rollback_en,
  output bp_pkg::rob_idx_t                   rollback_rob_idx,
  output bp_pkg::fl_idx_t                    rollback_fl_idx,
  output bp_pkg::lsq_idx_t                   rollback_sq_idx,
  output bp_pkg::lsq_idx_t                   rollback_lq_idx,
  input  wire                                cyc,
  input  wire                                stb,
  input  wire                                we,
  input  wire bp_pkg::wb_addr_t              adr,
  input  wire bp_pkg::wb_data_t              dat_w,
  output bp_pkg::wb_data_t                   dat_r,
  output logic                               ack
);

  bp_pkg::bh_idx_t              lookup_idx    [bp_pkg::num_super];
  bp_pkg::counter_t             lookup_ctr    [bp_pkg::num_super];
  bp_pkg::pc_t                  lookup_target [bp_pkg::num_super];
  bp_pkg::bh_idx_t              ctr_upd_idx   [bp_pkg::num_super];
  logic [bp_pkg::num_super-1:0] ctr_upd;
  logic [bp_pkg::num_super-1:0] ctr_taken;
  logic                         btb_wr;
  bp_pkg::bh_idx_t              btb_wr_idx;
  bp_pkg::pc_t                  btb_wr_target;
  bp_pkg::pc_t                  rollback_target;
  logic                         mispredict_evt;
  logic                         ld_violate_evt;
  logic                         predict_enable;

  bp_tables u_tables (.*);

  bp_predict u_predict (.*);

  bp_rollback u_rollback (.*);  // also drives fetch redirect

  bp_csr u_csr (.*);

endmodule

`default_nettype wire

//--- verif/bp_tb_ref.svh
`ifndef BP_TB_REF_SVH
`define BP_TB_REF_SVH

// shadow state of the predictor and the register block
bp_pkg::counter_t sh_ctr [bp_pkg::bh_entries];
bp_pkg::pc_t      sh_btb [bp_pkg::bh_entries];
bp_pkg::counter_t nx_ctr [bp_pkg::bh_entries];
bp_pkg::pc_t      nx_btb [bp_pkg::bh_entries];
logic             sh_enable;
bp_pkg::wb_data_t sh_misp_cnt;
bp_pkg::wb_data_t sh_ldv_cnt;

// expected outputs of the current cycle
int               win;  // 0 or 1 branch lane, 2 load, -1 none
logic             exp_rb_en;
bp_pkg::rob_idx_t exp_rob;
bp_pkg::fl_idx_t  exp_fl;
bp_pkg::lsq_idx_t exp_sq;
bp_pkg::lsq_idx_t exp_lq;
bp_pkg::pc_t      exp_rb_target;
logic [1:0]       exp_take;
logic [1:0]       exp_valid;
bp_pkg::pc_t      exp_target;

function automatic logic ref_is_cond(input logic [5:0] op);
  return op[5:3] == 3'b111;  // 38 to 3f
endfunction

function automatic logic ref_is_uncond(input logic [5:0] op);
  return op == 6'h30 || op == 6'h34 || op == 6'h1a;
endfunction

function automatic bp_pkg::counter_t ref_sat(input bp_pkg::counter_t c, input logic taken);
  if (taken) begin
    return (c == 2'd3) ? c : c + 2'd1;
  end
  return (c == 2'd0) ? c : c - 2'd1;
endfunction

// oldest request wins, scanned lane 0, lane 1, load so that ties keep the earlier
function automatic void ref_rollback();
  bp_pkg::rob_idx_t age;
  bp_pkg::rob_idx_t best_age;
  bp_pkg::pc_t      actual;
  win      = -1;
  best_age = '0;
  for (int i = 0; i < 2; i++) begin
    actual = br_taken[i] ? br_target_pc[i] : br_npc[i];
    if (br_done[i] && actual != br_pred_target[i]) begin
      age = dispatch_rob_idx - br_rob_idx[i];
      if (win < 0 || age > best_age) begin
        win      = i;
        best_age = age;
      end
    end
  end
  if (ld_violate) begin
    age = dispatch_rob_idx - ld_rob_idx;
    if (win < 0 || age > best_age) begin
      win = 2;
    end
  end
  exp_rb_en = win >= 0;
  if (win == 2) begin
    exp_rob       = ld_rob_idx;
    exp_fl        = ld_fl_idx;
    exp_sq        = ld_sq_idx;
    exp_lq        = ld_lq_idx;
    exp_rb_target = ld_target_pc;
  end else if (win >= 0) begin
    exp_rob       = br_rob_idx[win];
    exp_fl        = br_fl_idx[win];
    exp_sq        = br_sq_idx[win];
    exp_lq        = br_lq_idx[win];
    exp_rb_target = br_taken[win] ? br_target_pc[win] : br_npc[win];
  end
endfunction

// table contents after this cycle's updates
function automatic void ref_tables();
  bp_pkg::pc_t pc;
  nx_ctr = sh_ctr;
  nx_btb = sh_btb;
  for (int i = 0; i < 2; i++) begin
    if (br_done[i]) begin
      pc = br_npc[i] - 32'd4;
      nx_ctr[pc[5:2]] = ref_sat(nx_ctr[pc[5:2]], br_taken[i]);
    end
  end
  if ((win == 0 || win == 1) && br_taken[win]) begin
    pc = br_npc[win] - 32'd4;
    nx_btb[pc[5:2]] = br_target_pc[win];
  end
endfunction

function automatic void ref_predict();
  logic [1:0]  tk;
  logic [5:0]  op;
  bp_pkg::pc_t pc;
  for (int i = 0; i < 2; i++) begin
    op    = fetch_inst[i][31:26];
    pc    = fetch_pc[i];
    tk[i] = fetch_valid[i] && (ref_is_uncond(op) ||
            (ref_is_cond(op) && sh_enable && nx_ctr[pc[5:2]][1]));
  end
  if (exp_rb_en) begin
    exp_take   = 2'b11;
    exp_valid  = 2'b00;
    exp_target = exp_rb_target;
  end else begin
    exp_take     = tk;
    exp_valid[0] = fetch_valid[0];
    exp_valid[1] = fetch_valid[1] && !tk[0];
    pc = fetch_pc[0];
    if (tk[0]) begin
      exp_target = nx_btb[pc[5:2]];
    end else begin
      pc = fetch_pc[1];
      exp_target = tk[1] ? nx_btb[pc[5:2]] : pc + 32'd4;
    end
  end
endfunction

`endif

//--- verif/bp_tb.sv
`default_nettype none

module bp_tb;

  localparam int n_decode    = 200;
  localparam int n_arb       = 300;
  localparam int test_cycles = n_decode + n_arb + 40 + 10 + 120;
  localparam int time_limit  = (8 + test_cycles) * 100 * 2 + 5000;
  localparam bp_pkg::pc_t train_pc = 32'h0000_1010;  // index 4

  logic                 clock = 1'b0;
  logic                 reset;
  bp_pkg::pc_t          fetch_pc [2];
  bp_pkg::inst_t        fetch_inst [2];
  logic [1:0]           fetch_valid;
  logic [1:0]           pred_take;
  logic [1:0]           pred_valid;
  bp_pkg::pc_t          pred_target;
  logic [1:0]           br_done;
  logic [1:0]           br_taken;
  bp_pkg::pc_t          br_npc [2];
  bp_pkg::pc_t          br_target_pc [2];
  bp_pkg::pc_t          br_pred_target [2];
  bp_pkg::rob_idx_t     br_rob_idx [2];
  bp_pkg::fl_idx_t      br_fl_idx [2];
  bp_pkg::lsq_idx_t     br_sq_idx [2];
  bp_pkg::lsq_idx_t     br_lq_idx [2];
  logic                 ld_violate;
  bp_pkg::rob_idx_t     ld_rob_idx;
  bp_pkg::fl_idx_t      ld_fl_idx;
  bp_pkg::lsq_idx_t     ld_sq_idx;
  bp_pkg::lsq_idx_t     ld_lq_idx;
  bp_pkg::pc_t          ld_target_pc;
  bp_pkg::rob_idx_t     dispatch_rob_idx;
  logic                 rollback_en;
  bp_pkg::rob_idx_t     rollback_rob_idx;
  bp_pkg::fl_idx_t      rollback_fl_idx;
  bp_pkg::lsq_idx_t     rollback_sq_idx;
  bp_pkg::lsq_idx_t     rollback_lq_idx;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  bp_pkg::wb_addr_t     adr;
  bp_pkg::wb_data_t     dat_w;
  bp_pkg::wb_data_t     dat_r;
  logic                 ack;

  int                   errors = 0;
  int                   checks = 0;
  logic [15:0]          lfsr = 16'd15710;
  logic                 exp_ack;
  logic                 prev_ack;
  bp_pkg::wb_data_t     exp_rd;

  `include "bp_tb_ref.svh"

  bp_top UUT (.*);

  always #50 clock = ~clock;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic check_pc(input string name, input bp_pkg::pc_t got, input bp_pkg::pc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rob(input string name, input bp_pkg::rob_idx_t got,
                           input bp_pkg::rob_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_fl(input string name, input bp_pkg::fl_idx_t got,
                          input bp_pkg::fl_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_lsq(input string name, input bp_pkg::lsq_idx_t got,
                           input bp_pkg::lsq_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input bp_pkg::wb_data_t got,
                            input bp_pkg::wb_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // outputs sampled mid cycle and shadow advanced to the next edge
  always @(negedge clock) begin
    if (reset) begin
      for (int e = 0; e < bp_pkg::bh_entries; e++) begin
        sh_ctr[e] = 2'b01;
        sh_btb[e] = '0;
      end
      sh_enable   = 1'b1;
      sh_misp_cnt = '0;
      sh_ldv_cnt  = '0;
      exp_ack     = 1'b0;
      prev_ack    = 1'b0;
    end else begin
      ref_rollback();
      ref_tables();
      ref_predict();
      check_bit("rollback_en", rollback_en, exp_rb_en);
      if (exp_rb_en) begin
        check_rob("rollback_rob_idx", rollback_rob_idx, exp_rob);
        check_fl("rollback_fl_idx", rollback_fl_idx, exp_fl);
        check_lsq("rollback_sq_idx", rollback_sq_idx, exp_sq);
        check_lsq("rollback_lq_idx", rollback_lq_idx, exp_lq);
      end
      check_bit("pred_take[0]", pred_take[0], exp_take[0]);
      check_bit("pred_take[1]", pred_take[1], exp_take[1]);
      check_bit("pred_valid[0]", pred_valid[0], exp_valid[0]);
      check_bit("pred_valid[1]", pred_valid[1], exp_valid[1]);
      check_pc("pred_target", pred_target, exp_target);
      check_bit("ack", ack, exp_ack);
      if (ack && prev_ack) begin
        errors++;
        $display("ack stayed high for two cycles at %0t", $time);
      end
      if (ack && exp_ack) begin
        check_data("dat_r", dat_r, exp_rd);
      end
      prev_ack = ack;
      sh_ctr   = nx_ctr;
      sh_btb   = nx_btb;
      // read data is the register value before this edge
      if (cyc && stb && !exp_ack) begin
        case (adr[3:2])
          2'd0:    exp_rd = {31'd0, sh_enable};
          2'd1:    exp_rd = sh_misp_cnt;
          2'd2:    exp_rd = sh_ldv_cnt;
          default: exp_rd = '0;
        endcase
        if (we && adr[3:2] == 2'd0) begin
          sh_enable = dat_w[0];
        end
      end
      if (cyc && stb && !exp_ack && we && adr[3:2] == 2'd1) begin
        sh_misp_cnt = '0;
      end else if ((win == 0 || win == 1) && sh_misp_cnt != '1) begin
        sh_misp_cnt = sh_misp_cnt + 32'd1;
      end
      if (cyc && stb && !exp_ack && we && adr[3:2] == 2'd2) begin
        sh_ldv_cnt = '0;
      end else if (win == 2 && sh_ldv_cnt != '1) begin
        sh_ldv_cnt = sh_ldv_cnt + 32'd1;
      end
      exp_ack = cyc && stb && !exp_ack;
    end
  end

  task automatic clear_inputs();
    for (int i = 0; i < 2; i++) begin
      fetch_pc[i]       <= '0;
      fetch_inst[i]     <= '0;
      br_npc[i]         <= '0;
      br_target_pc[i]   <= '0;
      br_pred_target[i] <= '0;
      br_rob_idx[i]     <= '0;
      br_fl_idx[i]      <= '0;
      br_sq_idx[i]      <= '0;
      br_lq_idx[i]      <= '0;
    end
    fetch_valid      <= '0;
    br_done          <= '0;
    br_taken         <= '0;
    ld_violate       <= 1'b0;
    ld_rob_idx       <= '0;
    ld_fl_idx        <= '0;
    ld_sq_idx        <= '0;
    ld_lq_idx        <= '0;
    ld_target_pc     <= '0;
    dispatch_rob_idx <= '0;
    cyc              <= 1'b0;
    stb              <= 1'b0;
    we               <= 1'b0;
    adr              <= '0;
    dat_w            <= '0;
  endtask

  function automatic bp_pkg::inst_t random_inst();
    logic [31:0] sel;
    logic [31:0] low;
    logic [5:0]  op;
    sel = rand_bits(3);
    low = rand_bits(26);
    case (sel[2:0])
      3'd0, 3'd1, 3'd2, 3'd3: op = 6'h38 | 6'(rand_bits(3));
      3'd4:    op = 6'h30;
      3'd5:    op = 6'h34;
      3'd6:    op = 6'h1a;
      default: op = 6'h10 | 6'(rand_bits(3));  // not a branch
    endcase
    return {op, low[25:0]};
  endfunction

  task automatic fetch_random();
    logic [31:0] r;
    r = rand_bits(30);
    fetch_pc[0]   <= {r[29:0], 2'b00};
    fetch_pc[1]   <= {r[29:0], 2'b00} + 32'd4;
    fetch_inst[0] <= random_inst();
    fetch_inst[1] <= random_inst();
    r = rand_bits(2);
    fetch_valid   <= r[1:0];
  endtask

  task automatic fetch_at(input bp_pkg::pc_t pc, input logic [5:0] op);
    fetch_pc[0]   <= pc;
    fetch_pc[1]   <= pc + 32'd4;
    fetch_inst[0] <= {op, 26'h0};
    fetch_inst[1] <= '0;
    fetch_valid   <= 2'b01;
  endtask

  // resolve a lane 0 branch at train_pc
  task automatic resolve_at(input logic taken, input bp_pkg::pc_t target, input logic wrong);
    bp_pkg::pc_t actual;
    actual = taken ? target : train_pc + 32'd4;
    br_done           <= 2'b01;
    br_taken          <= {1'b0, taken};
    br_npc[0]         <= train_pc + 32'd4;
    br_target_pc[0]   <= target;
    br_pred_target[0] <= wrong ? actual ^ 32'h40 : actual;
    ld_violate        <= 1'b0;
  endtask

  task automatic arb_cycle();
    logic [31:0] r;
    bp_pkg::pc_t pc;
    bp_pkg::pc_t tgt;
    fetch_random();
    r = rand_bits(5);
    dispatch_rob_idx <= r[4:0];
    r = rand_bits(2);
    br_done  <= r[1:0];
    r = rand_bits(2);
    br_taken <= r[1:0];
    for (int i = 0; i < 2; i++) begin
      r   = rand_bits(30);
      pc  = {r[29:0], 2'b00};
      r   = rand_bits(30);
      tgt = {r[29:0], 2'b00};
      br_npc[i]       <= pc + 32'd4;
      br_target_pc[i] <= tgt;
      r = rand_bits(1);
      br_pred_target[i] <= r[0] ? pc + 32'd4 : tgt;
      r = rand_bits(2);
      br_rob_idx[i] <= {3'd0, r[1:0]};  // narrow range makes ties common
      r = rand_bits(11);
      br_fl_idx[i]  <= r[4:0];
      br_sq_idx[i]  <= r[7:5];
      br_lq_idx[i]  <= r[10:8];
    end
    r = rand_bits(14);
    ld_violate   <= r[0];
    ld_rob_idx   <= {3'd0, r[2:1]};
    ld_fl_idx    <= r[7:3];
    ld_sq_idx    <= r[10:8];
    ld_lq_idx    <= r[13:11];
    r = rand_bits(30);
    ld_target_pc <= {r[29:0], 2'b00};
  endtask

  task automatic wb_xfer(input logic write, input bp_pkg::wb_addr_t a, input bp_pkg::wb_data_t d);
    int waited;
    @(posedge clock);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= a;
    dat_w <= d;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!ack && waited < 4);
    if (!ack) begin
      errors++;
      $display("no ack for the register access at %0t", $time);
    end
    @(posedge clock);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(posedge clock);
  endtask

  initial begin
    #(time_limit);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clear_inputs();
    reset <= 1'b1;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    // decode and direction
    repeat (n_decode) begin
      @(posedge clock);
      fetch_random();
    end

    // counter training with a same cycle fetch through the bypass
    for (int k = 0; k < 12; k++) begin
      @(posedge clock);
      fetch_at(train_pc, bp_pkg::op_beq);
      resolve_at(k < 6, 32'h0000_8000, 1'b0);
    end

    // target buffer write from a mispredicted taken branch
    @(posedge clock);
    fetch_at(32'h0000_2000, 6'h10);
    resolve_at(1'b1, 32'h0000_a5a0, 1'b1);
    @(posedge clock);
    br_done <= 2'b00;
    fetch_at(train_pc, bp_pkg::op_br);
    @(posedge clock);

    repeat (n_arb) begin
      @(posedge clock);
      arb_cycle();
    end

    // registers
    for (int k = 0; k < 3; k++) begin
      @(posedge clock);
      fetch_at(train_pc, bp_pkg::op_bne);
      resolve_at(1'b1, 32'h0000_8000, 1'b0);
    end
    @(posedge clock);
    br_done    <= 2'b00;
    ld_violate <= 1'b0;
    wb_xfer(1'b1, bp_pkg::reg_ctrl, 32'd0);
    repeat (3) @(posedge clock);
    wb_xfer(1'b0, bp_pkg::reg_ctrl, 32'd0);
    wb_xfer(1'b1, bp_pkg::reg_ctrl, 32'd1);
    repeat (2) @(posedge clock);
    wb_xfer(1'b0, bp_pkg::reg_mispredict, 32'd0);
    wb_xfer(1'b0, bp_pkg::reg_ld_violate, 32'd0);
    wb_xfer(1'b1, bp_pkg::reg_mispredict, 32'd0);
    wb_xfer(1'b1, bp_pkg::reg_ld_violate, 32'd0);
    wb_xfer(1'b0, bp_pkg::reg_mispredict, 32'd0);
    wb_xfer(1'b0, bp_pkg::reg_ld_violate, 32'd0);
    repeat (2) @(posedge clock);
    @(negedge clock);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
